//--- hw/texturePkg.sv
//////////////////////////////
// RGBA4444 texels, 1.15 coordinates
// Upload stream is fixed at 32 bits
// Sides from 1 to 128 texels
//////////////////////////////
`default_nettype none

package texturePkg;

    localparam int TEXEL_WIDTH     = 16;
    localparam int CHANNEL_WIDTH   = 4;
    localparam int STREAM_WIDTH    = 32;
    localparam int TEXELS_PER_WORD = STREAM_WIDTH / TEXEL_WIDTH;

    // Coordinate and filter weight layout
    localparam int COORD_FRAC_BITS = 15;
    localparam int FRAC_WIDTH      = 4;
    localparam int MAX_SIZE_EXP    = 7;

    // Red in 15..12, alpha in 3..0
    typedef logic [TEXEL_WIDTH - 1 : 0] texel_t;

    typedef logic [COORD_FRAC_BITS : 0] texCoord_t;     // 32768 is one full width

    typedef logic [2 : 0] sizeExp_t;                    // log2 of one side

    // Bit k set for 2**k texels, zero for a single texel
    typedef logic [MAX_SIZE_EXP : 0] sizeOneHot_t;

    typedef logic [STREAM_WIDTH - 1 : 0] streamWord_t;  // Even column in the low half

    typedef logic [1 : 0] cfgAddr_t;

    localparam cfgAddr_t CFG_SIZE_X = 2'd0;
    localparam cfgAddr_t CFG_SIZE_Y = 2'd1;
    localparam cfgAddr_t CFG_MODE   = 2'd2;             // Bit 0 selects bilinear

endpackage

`default_nettype wire

//--- hw/trueDualPortRam.sv
//////////////////////////////
// Port A writes or reads, port B reads
// Read data is registered on both ports
// Port A keeps its last read data while writing
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module trueDualPortRam #(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 16
)
(
    input  wire                         aclk,

    // Write or read port
    input  wire                         portAWrite,
    input  wire  [ADDR_WIDTH - 1 : 0]   portAAddr,
    input  wire  [DATA_WIDTH - 1 : 0]   portAWriteData,
    output logic [DATA_WIDTH - 1 : 0]   portAReadData,

    // Read only port
    input  wire  [ADDR_WIDTH - 1 : 0]   portBAddr,
    output logic [DATA_WIDTH - 1 : 0]   portBReadData
);

    logic [DATA_WIDTH - 1 : 0] mem [2 ** ADDR_WIDTH];

    always_ff @(posedge aclk)
    begin
        if (portAWrite)
        begin
            mem[portAAddr] <= portAWriteData;
        end
        else
        begin
            portAReadData <= mem[portAAddr];
        end
    end

    // Second port never writes
    always_ff @(posedge aclk)
    begin
        portBReadData <= mem[portBAddr];
    end

endmodule

`default_nettype wire

//--- hw/textureBuffer.sv
//////////////////////////////
// Even and odd column banks, MEM_SIZE_LOG2 up to 15
// Width times height must fit the memory
// Sampling during an upload gives undefined row 1 texels
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module textureBuffer #(
    parameter int MEM_SIZE_LOG2 = 14        // Memory size in bytes, log2
)
(
    input  wire                             aclk,
    input  wire                             resetn,

    input  wire texturePkg::sizeOneHot_t    textureSizeX,
    input  wire texturePkg::sizeOneHot_t    textureSizeY,

    // Quad read
    input  wire texturePkg::texCoord_t      texelX,
    input  wire texturePkg::texCoord_t      texelY,
    output texturePkg::texel_t              texel00,
    output texturePkg::texel_t              texel01,
    output texturePkg::texel_t              texel10,
    output texturePkg::texel_t              texel11,

    // Upload stream
    input  wire                             sAxisTvalid,
    output logic                            sAxisTready,
    input  wire                             sAxisTlast,
    input  wire texturePkg::streamWord_t    sAxisTdata
);
    import texturePkg::*;

    localparam int ADDR_WIDTH = MEM_SIZE_LOG2 - 2;  // Two bytes per texel, two banks

    typedef logic [ADDR_WIDTH - 1 : 0]   bankAddr_t;
    typedef logic [ADDR_WIDTH : 0]       linIndex_t;
    typedef logic [MAX_SIZE_EXP - 1 : 0] texIndex_t;

    // Top coordinate bits, as many as the side has index bits
    function automatic texIndex_t coordIndex(texCoord_t coord, sizeOneHot_t size);
        texIndex_t idx;
        idx = '0;
        for (int k = 1; k <= MAX_SIZE_EXP; k++)
        begin
            if (size[k])
            begin
                idx = coord[COORD_FRAC_BITS - 1 -: MAX_SIZE_EXP] >> (MAX_SIZE_EXP - k);
            end
        end
        return idx;
    endfunction

    // Repeat mode neighbour
    function automatic texIndex_t nextIndex(texIndex_t idx, sizeOneHot_t size);
        texIndex_t mask;
        mask = (size == '0) ? '0 : texIndex_t'(size - 1'b1);
        return (idx + 1'b1) & mask;
    endfunction

    function automatic linIndex_t linearIndex(
        texIndex_t   row,
        texIndex_t   col,
        sizeOneHot_t sizeX
    );
        logic [2 * MAX_SIZE_EXP - 1 : 0] lin;
        lin = {{MAX_SIZE_EXP{1'b0}}, row};      // Single column
        for (int k = 1; k <= MAX_SIZE_EXP; k++)
        begin
            if (sizeX[k])
            begin
                lin = ({{MAX_SIZE_EXP{1'b0}}, row} << k) | {{MAX_SIZE_EXP{1'b0}}, col};
            end
        end
        return linIndex_t'(lin);
    endfunction

    // A bank serves whichever texel of the pair falls into it
    function automatic bankAddr_t pickAddr(linIndex_t first, linIndex_t second, logic bank);
        return (first[0] == bank) ? first[ADDR_WIDTH : 1] : second[ADDR_WIDTH : 1];
    endfunction

    bankAddr_t    uploadAddr;
    texIndex_t    col0;
    texIndex_t    col1;
    texIndex_t    row0;
    texIndex_t    row1;
    linIndex_t    lin00;
    linIndex_t    lin01;
    linIndex_t    lin10;
    linIndex_t    lin11;
    logic [3 : 0] quadOdd;                      // Bank of each quad texel, one cycle late

    wire bankAddr_t bankAddrA [TEXELS_PER_WORD];
    wire bankAddr_t bankAddrB [TEXELS_PER_WORD];
    wire texel_t    bankWriteData [TEXELS_PER_WORD];
    wire texel_t    bankReadA [TEXELS_PER_WORD];
    wire texel_t    bankReadB [TEXELS_PER_WORD];

    always_comb
    begin
        col0  = coordIndex(texelX, textureSizeX);
        col1  = nextIndex(col0, textureSizeX);
        row0  = coordIndex(texelY, textureSizeY);
        row1  = nextIndex(row0, textureSizeY);
        lin00 = linearIndex(row0, col0, textureSizeX);
        lin01 = linearIndex(row0, col1, textureSizeX);
        lin10 = linearIndex(row1, col0, textureSizeX);
        lin11 = linearIndex(row1, col1, textureSizeX);
    end

    // Bank 0 holds even columns, bank 1 odd ones
    for (genvar b = 0; b < TEXELS_PER_WORD; b++)
    begin : bankGen
        assign bankWriteData[b] = sAxisTdata[b * TEXEL_WIDTH +: TEXEL_WIDTH];

        // Row 1 shares port A with the upload
        assign bankAddrA[b] = sAxisTvalid ? uploadAddr : pickAddr(lin10, lin11, 1'(b));
        assign bankAddrB[b] = pickAddr(lin00, lin01, 1'(b));

        trueDualPortRam #(
            .ADDR_WIDTH(ADDR_WIDTH),
            .DATA_WIDTH(TEXEL_WIDTH)
        ) u_bank (
            .aclk(aclk),
            .portAWrite(sAxisTvalid),
            .portAAddr(bankAddrA[b]),
            .portAWriteData(bankWriteData[b]),
            .portAReadData(bankReadA[b]),
            .portBAddr(bankAddrB[b]),
            .portBReadData(bankReadB[b])
        );
    end

    // Also covers one texel wide textures, where both pair texels share a bank
    always_ff @(posedge aclk)
    begin
        quadOdd <= {lin11[0], lin10[0], lin01[0], lin00[0]};
    end

    assign texel00 = bankReadB[quadOdd[0]];
    assign texel01 = bankReadB[quadOdd[1]];
    assign texel10 = bankReadA[quadOdd[2]];
    assign texel11 = bankReadA[quadOdd[3]];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            uploadAddr  <= '0;
            sAxisTready <= 1'b0;
        end
        else
        begin
            sAxisTready <= 1'b1;                // No back-pressure
            if (sAxisTvalid)
            begin
                uploadAddr <= sAxisTlast ? '0 : uploadAddr + 1'b1;
            end
        end
    end

    sizeOneHot: assert property (@(posedge aclk) disable iff (!resetn)
        $onehot0(textureSizeX) && $onehot0(textureSizeY))
        else $error("Texture size is not one-hot");

    // An upload longer than a bank would wrap onto its own start
    uploadInBank: assert property (@(posedge aclk) disable iff (!resetn)
        sAxisTvalid && !sAxisTlast |=> uploadAddr != '0)
        else $error("Upload ran past the bank depth");

endmodule

`default_nettype wire

//--- hw/textureConfig.sv
//////////////////////////////
// All registers clear to 1x1 and nearest
// Address 3 is unused
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module textureConfig
(
    input  wire                             aclk,
    input  wire                             resetn,

    input  wire                             cfgWrite,
    input  wire texturePkg::cfgAddr_t       cfgAddr,
    input  wire  [7 : 0]                    cfgData,

    output texturePkg::sizeExp_t            sizeExpX,
    output texturePkg::sizeExp_t            sizeExpY,
    output texturePkg::sizeOneHot_t         textureSizeX,
    output texturePkg::sizeOneHot_t         textureSizeY,
    output logic                            bilinear
);
    import texturePkg::*;

    // Zero exponent is a single texel and decodes to all zeros
    function automatic sizeOneHot_t toOneHot(sizeExp_t sizeExp);
        return (sizeExp == '0) ? '0 : sizeOneHot_t'(1) << sizeExp;
    endfunction

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            sizeExpX <= '0;
            sizeExpY <= '0;
            bilinear <= 1'b0;
        end
        else if (cfgWrite)
        begin
            case (cfgAddr)
                CFG_SIZE_X: sizeExpX <= sizeExp_t'(cfgData);
                CFG_SIZE_Y: sizeExpY <= sizeExp_t'(cfgData);
                CFG_MODE:   bilinear <= cfgData[0];
                default:    ;
            endcase
        end
    end

    assign textureSizeX = toOneHot(sizeExpX);
    assign textureSizeY = toOneHot(sizeExpY);

endmodule

`default_nettype wire

//--- hw/texelFilter.sv
//////////////////////////////
// Two stages, quad arrives one cycle after the coordinates
// Bilinear weights are 4-bit fractions, floor at each step
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module texelFilter
(
    input  wire                             aclk,
    input  wire                             resetn,

    input  wire                             sampleValid,
    input  wire texturePkg::texCoord_t      texelX,
    input  wire texturePkg::texCoord_t      texelY,
    input  wire texturePkg::sizeExp_t       sizeExpX,
    input  wire texturePkg::sizeExp_t       sizeExpY,
    input  wire                             bilinear,

    // Quad from the buffer
    input  wire texturePkg::texel_t         texel00,
    input  wire texturePkg::texel_t         texel01,
    input  wire texturePkg::texel_t         texel10,
    input  wire texturePkg::texel_t         texel11,

    output logic                            pixelValid,
    output texturePkg::texel_t              pixel
);
    import texturePkg::*;

    typedef logic [FRAC_WIDTH - 1 : 0]    frac_t;
    typedef logic [CHANNEL_WIDTH - 1 : 0] channel_t;

    // Bits just below the index; zeros shift in below bit 0
    function automatic frac_t fracOf(texCoord_t coord, sizeExp_t sizeExp);
        logic [COORD_FRAC_BITS - 1 : 0] shifted;
        shifted = coord[COORD_FRAC_BITS - 1 : 0] << sizeExp;
        return shifted[COORD_FRAC_BITS - 1 -: FRAC_WIDTH];
    endfunction

    function automatic channel_t lerp(channel_t a, channel_t b, frac_t w);
        logic [CHANNEL_WIDTH + FRAC_WIDTH : 0] sum;
        sum = a * (2 ** FRAC_WIDTH - w) + b * w;
        return sum[FRAC_WIDTH +: CHANNEL_WIDTH];   // Floor of sum / 16
    endfunction

    frac_t  fracXD;
    frac_t  fracYD;
    logic   validD;
    texel_t blended;

    always_ff @(posedge aclk)
    begin
        fracXD <= fracOf(texelX, sizeExpX);
        fracYD <= fracOf(texelY, sizeExpY);
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            validD     <= 1'b0;
            pixelValid <= 1'b0;
        end
        else
        begin
            validD     <= sampleValid;
            pixelValid <= validD;
        end
    end

    // Horizontal pair first, then vertical, per channel
    always_comb
    begin
        for (int c = 0; c < TEXEL_WIDTH / CHANNEL_WIDTH; c++)
        begin
            blended[c * CHANNEL_WIDTH +: CHANNEL_WIDTH] = lerp(
                lerp(texel00[c * CHANNEL_WIDTH +: CHANNEL_WIDTH],
                     texel01[c * CHANNEL_WIDTH +: CHANNEL_WIDTH], fracXD),
                lerp(texel10[c * CHANNEL_WIDTH +: CHANNEL_WIDTH],
                     texel11[c * CHANNEL_WIDTH +: CHANNEL_WIDTH], fracXD),
                fracYD);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (validD)
        begin
            pixel <= bilinear ? blended : texel00;  // Nearest bypasses the arithmetic
        end
    end

endmodule

`default_nettype wire

//--- hw/textureUnit.sv
//////////////////////////////
// Result two cycles after a sample request
// Do not sample while uploading
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module textureUnit #(
    parameter int MEM_SIZE_LOG2 = 14
)
(
    input  wire                             aclk,
    input  wire                             resetn,

    input  wire                             cfgWrite,
    input  wire texturePkg::cfgAddr_t       cfgAddr,
    input  wire  [7 : 0]                    cfgData,

    input  wire                             sAxisTvalid,
    output logic                            sAxisTready,
    input  wire                             sAxisTlast,
    input  wire texturePkg::streamWord_t    sAxisTdata,

    input  wire                             sampleValid,
    input  wire texturePkg::texCoord_t      texelX,
    input  wire texturePkg::texCoord_t      texelY,

    output logic                            pixelValid,
    output texturePkg::texel_t              pixel
);
    import texturePkg::*;

    sizeExp_t    sizeExpX;
    sizeExp_t    sizeExpY;
    sizeOneHot_t textureSizeX;
    sizeOneHot_t textureSizeY;
    logic        bilinear;
    texel_t      texel00;
    texel_t      texel01;
    texel_t      texel10;
    texel_t      texel11;

    textureConfig u_config (
        .aclk(aclk),
        .resetn(resetn),
        .cfgWrite(cfgWrite),
        .cfgAddr(cfgAddr),
        .cfgData(cfgData),
        .sizeExpX(sizeExpX),
        .sizeExpY(sizeExpY),
        .textureSizeX(textureSizeX),
        .textureSizeY(textureSizeY),
        .bilinear(bilinear)
    );

    textureBuffer #(
        .MEM_SIZE_LOG2(MEM_SIZE_LOG2)
    ) u_buffer (
        .aclk(aclk),
        .resetn(resetn),
        .textureSizeX(textureSizeX),
        .textureSizeY(textureSizeY),
        .texelX(texelX),
        .texelY(texelY),
        .texel00(texel00),
        .texel01(texel01),
        .texel10(texel10),
        .texel11(texel11),
        .sAxisTvalid(sAxisTvalid),
        .sAxisTready(sAxisTready),
        .sAxisTlast(sAxisTlast),
        .sAxisTdata(sAxisTdata)
    );

    texelFilter u_filter (
        .aclk(aclk),
        .resetn(resetn),
        .sampleValid(sampleValid),
        .texelX(texelX),
        .texelY(texelY),
        .sizeExpX(sizeExpX),
        .sizeExpY(sizeExpY),
        .bilinear(bilinear),
        .texel00(texel00),
        .texel01(texel01),
        .texel10(texel10),
        .texel11(texel11),
        .pixelValid(pixelValid),
        .pixel(pixel)
    );

    // Two bytes per texel, so texels = 2**(MEM_SIZE_LOG2 - 1)
    sizeFitsMemory: assert property (@(posedge aclk) disable iff (!resetn)
        int'(sizeExpX) + int'(sizeExpY) + 1 <= MEM_SIZE_LOG2)
        else $error("Texture 2**%0d x 2**%0d exceeds the memory", sizeExpX, sizeExpY);

endmodule

`default_nettype wire

//--- tests/tbClock.sv
//////////////////////////////
// Free running clock
// Reset is released on a falling edge
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD       = 20,        // ns
    parameter int RESET_CYCLES = 8
)
(
    output logic aclk,
    output logic resetn
);

    initial
    begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/textureUnitTb.sv
//////////////////////////////
// Random uploads and samples against a texel model
// Samples are never issued during an upload
// Model assumes the default memory size
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module textureUnitTb;
    import texturePkg::*;

    localparam int MEM_SIZE_LOG2 = 14;
    localparam int CLOCK_PERIOD  = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int MODEL_DEPTH   = 2 ** (MEM_SIZE_LOG2 - 1);   // Texels

    localparam int NEAREST_SAMPLES  = 40;
    localparam int WRAP_SAMPLES     = 16;
    localparam int BILINEAR_ROUNDS  = 3;
    localparam int BILINEAR_SAMPLES = 40;
    localparam int BURST_SAMPLES    = 24;
    localparam int PARTIAL_WORDS    = 100;
    localparam int SINGLE_SAMPLES   = 12;

    localparam int TOTAL_SAMPLES = 2 * NEAREST_SAMPLES + WRAP_SAMPLES
        + BILINEAR_ROUNDS * BILINEAR_SAMPLES + 2 * BURST_SAMPLES + 2 * SINGLE_SAMPLES;
    // 16x16, 64x32, 16x8, largest bilinear rounds, 32x32, rewrite, 1x1
    localparam int TOTAL_WORDS = 128 + 1024 + 64 + BILINEAR_ROUNDS * 2048 + 512
        + PARTIAL_WORDS + 1;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 + 40 * TOTAL_SAMPLES + 2 * TOTAL_WORDS;

    wire         aclk;
    wire         resetn;
    logic        cfgWrite;
    cfgAddr_t    cfgAddr;
    logic [7 : 0] cfgData;
    logic        sAxisTvalid;
    wire         sAxisTready;
    logic        sAxisTlast;
    streamWord_t sAxisTdata;
    logic        sampleValid;
    texCoord_t   texelX;
    texCoord_t   texelY;
    wire         pixelValid;
    wire texel_t pixel;

    integer seed = 32'h66b6f748;
    int     cycleCount = 0;
    texel_t modelMem [MODEL_DEPTH];
    int     cfgExpX;
    int     cfgExpY;
    bit     cfgBilinear;
    texel_t expectedPixels [$];
    int     expectedCycles [$];

    tbClock #(
        .PERIOD(CLOCK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) u_clock (
        .aclk(aclk),
        .resetn(resetn)
    );

    textureUnit #(
        .MEM_SIZE_LOG2(MEM_SIZE_LOG2)
    ) u_dut (
        .aclk(aclk),
        .resetn(resetn),
        .cfgWrite(cfgWrite),
        .cfgAddr(cfgAddr),
        .cfgData(cfgData),
        .sAxisTvalid(sAxisTvalid),
        .sAxisTready(sAxisTready),
        .sAxisTlast(sAxisTlast),
        .sAxisTdata(sAxisTdata),
        .sampleValid(sampleValid),
        .texelX(texelX),
        .texelY(texelY),
        .pixelValid(pixelValid),
        .pixel(pixel)
    );

    task automatic stopWithFailure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic reportFailure(input string message);
        $display("%s", message);
        stopWithFailure();
    endtask

    task automatic checkValue(input string name, input logic [31 : 0] actual,
                              input logic [31 : 0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            stopWithFailure();
        end
    endtask

    function automatic int randomBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    // Index is the top sizeExp bits of the 15 fraction bits
    function automatic int coordToIndex(input texCoord_t coord, input int sizeExp);
        if (sizeExp == 0)
            return 0;
        return int'(coord[14 : 0]) >> (15 - sizeExp);
    endfunction

    function automatic int coordToFrac(input texCoord_t coord, input int sizeExp);
        int scaled;
        scaled = int'(coord[14 : 0]) << sizeExp;
        return (scaled >> 11) & 15;
    endfunction

    function automatic int blendChannel(input int a, input int b, input int weight);
        return (a * (16 - weight) + b * weight) / 16;       // Floor division
    endfunction

    function automatic texel_t expectedPixel(input texCoord_t x, input texCoord_t y);
        int     width;
        int     height;
        int     col;
        int     row;
        int     colNext;
        int     rowNext;
        int     top;
        int     bottom;
        texel_t t00;
        texel_t t01;
        texel_t t10;
        texel_t t11;
        texel_t result;
        width   = 1 << cfgExpX;
        height  = 1 << cfgExpY;
        col     = coordToIndex(x, cfgExpX);
        row     = coordToIndex(y, cfgExpY);
        colNext = (col + 1) % width;                          // Repeat mode
        rowNext = (row + 1) % height;
        t00 = modelMem[row * width + col];
        t01 = modelMem[row * width + colNext];
        t10 = modelMem[rowNext * width + col];
        t11 = modelMem[rowNext * width + colNext];
        if (!cfgBilinear)
            return t00;
        result = '0;
        for (int c = 0; c < 4; c++)
        begin
            top    = blendChannel(t00[4 * c +: 4], t01[4 * c +: 4], coordToFrac(x, cfgExpX));
            bottom = blendChannel(t10[4 * c +: 4], t11[4 * c +: 4], coordToFrac(x, cfgExpX));
            result[4 * c +: 4] = 4'(blendChannel(top, bottom, coordToFrac(y, cfgExpY)));
        end
        return result;
    endfunction

    // Coordinate on the last column or row with a random fraction and integer bit
    function automatic texCoord_t lastCoord(input int sizeExp);
        int span;
        span = 15 - sizeExp;
        return texCoord_t'((randomBelow(2) << 15) | (((1 << sizeExp) - 1) << span)
            | randomBelow(1 << span));
    endfunction

    function automatic int wordsFor(input int expX, input int expY);
        int texels;
        texels = 1 << (expX + expY);
        return (texels > 1) ? texels / 2 : 1;
    endfunction

    task automatic writeConfig(input cfgAddr_t addr, input logic [7 : 0] data);
        @(negedge aclk);
        cfgWrite = 1'b1;
        cfgAddr  = addr;
        cfgData  = data;
        @(negedge aclk);
        cfgWrite = 1'b0;
    endtask

    // Unused upper bits are filled at random
    task automatic setTexture(input int expX, input int expY, input bit mode);
        writeConfig(CFG_SIZE_X, 8'((randomBelow(32) << 3) | expX));
        writeConfig(CFG_SIZE_Y, 8'((randomBelow(32) << 3) | expY));
        writeConfig(CFG_MODE, 8'((randomBelow(128) << 1) | mode));
        cfgExpX     = expX;
        cfgExpY     = expY;
        cfgBilinear = mode;
    endtask

    task automatic uploadWords(input int numWords);
        texel_t evenTexel;
        texel_t oddTexel;
        for (int w = 0; w < numWords; w++)
        begin
            @(negedge aclk);
            checkValue("sAxisTready", 32'(sAxisTready), 32'd1);
            evenTexel   = texel_t'($random(seed));
            oddTexel    = texel_t'($random(seed));
            sAxisTvalid = 1'b1;
            sAxisTlast  = (w == numWords - 1);
            sAxisTdata  = {oddTexel, evenTexel};
            modelMem[2 * w]     = evenTexel;
            modelMem[2 * w + 1] = oddTexel;
        end
        @(negedge aclk);
        sAxisTvalid = 1'b0;
        sAxisTlast  = 1'b0;
    endtask

    // Captured on the next rising edge and returned two edges later
    task automatic driveSample(input texCoord_t x, input texCoord_t y);
        @(negedge aclk);
        sampleValid = 1'b1;
        texelX      = x;
        texelY      = y;
        expectedPixels.push_back(expectedPixel(x, y));
        expectedCycles.push_back(cycleCount + 3);
    endtask

    task automatic idleCycle();
        @(negedge aclk);
        sampleValid = 1'b0;
    endtask

    task automatic drainSamples();
        int waited;
        waited = 0;
        idleCycle();
        while (expectedPixels.size() != 0 && waited < 8)
        begin
            @(negedge aclk);
            waited++;
        end
        if (expectedPixels.size() != 0)
            reportFailure("Pending samples never produced pixelValid");
    endtask

    task automatic runSamples(input int count, input int maxGap, input texCoord_t yMask);
        for (int i = 0; i < count; i++)
        begin
            driveSample(texCoord_t'($random(seed)), texCoord_t'($random(seed)) & yMask);
            repeat (randomBelow(maxGap + 1)) idleCycle();
        end
        drainSamples();
    endtask

    task automatic runWrapSamples(input int count);
        for (int i = 0; i < count; i++)
        begin
            driveSample(lastCoord(cfgExpX), lastCoord(cfgExpY));
            repeat (randomBelow(2)) idleCycle();
        end
        drainSamples();
    endtask

    // Output monitor sees values from before the edge
    always @(posedge aclk)
    begin
        cycleCount++;
        if (resetn)
        begin
            if (pixelValid === 1'b1)
            begin
                if (expectedPixels.size() == 0)
                    reportFailure("pixelValid was high with no sample pending");
                checkValue("pixelValid cycle", cycleCount, expectedCycles[0]);
                checkValue("pixel", 32'(pixel), 32'(expectedPixels[0]));
                void'(expectedPixels.pop_front());
                void'(expectedCycles.pop_front());
            end
            else if (expectedCycles.size() != 0 && expectedCycles[0] <= cycleCount)
                checkValue("pixelValid", 32'(pixelValid), 32'd1);
            else
                checkValue("pixelValid", 32'(pixelValid), 32'd0);
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        reportFailure("Watchdog timeout, the tests did not finish in time");
    end

    initial
    begin
        int expX;
        int expY;
        cfgWrite    = 1'b0;
        cfgAddr     = '0;
        cfgData     = '0;
        sAxisTvalid = 1'b0;
        sAxisTlast  = 1'b0;
        sAxisTdata  = '0;
        sampleValid = 1'b0;
        texelX      = '0;
        texelY      = '0;

        wait (resetn === 1'b1);
        @(negedge aclk);
        checkValue("sAxisTready", 32'(sAxisTready), 32'd1);
        checkValue("pixelValid", 32'(pixelValid), 32'd0);

        setTexture(4, 4, 1'b0);
        writeConfig(cfgAddr_t'(3), 8'hff);              // Ignored by the DUT
        uploadWords(wordsFor(4, 4));
        runSamples(NEAREST_SAMPLES, 2, 16'hffff);
        setTexture(6, 5, 1'b0);
        uploadWords(wordsFor(6, 5));
        runSamples(NEAREST_SAMPLES, 2, 16'hffff);

        // Neighbours of the last column and row are column 0 and row 0
        setTexture(4, 3, 1'b1);
        uploadWords(wordsFor(4, 3));
        runWrapSamples(WRAP_SAMPLES);

        for (int r = 0; r < BILINEAR_ROUNDS; r++)
        begin
            expX = randomBelow(7);
            expY = randomBelow(7);
            setTexture(expX, expY, 1'b1);
            uploadWords(wordsFor(expX, expY));
            runSamples(BILINEAR_SAMPLES, 2, 16'hffff);
        end

        setTexture(5, 5, 1'b1);
        uploadWords(wordsFor(5, 5));
        runSamples(BURST_SAMPLES, 0, 16'hffff);
        uploadWords(PARTIAL_WORDS);                     // Restarts at address 0
        runSamples(BURST_SAMPLES, 0, 16'h8fff);         // Rows 0 to 3 only

        setTexture(0, 0, 1'b0);
        uploadWords(1);
        runSamples(SINGLE_SAMPLES, 1, 16'hffff);
        setTexture(0, 0, 1'b1);
        runSamples(SINGLE_SAMPLES, 1, 16'hffff);

        if (expectedPixels.size() == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
            reportFailure("Samples were left without a pixel at the end");
    end

endmodule

`default_nettype wire

//--- textureUnit.f
hw/texturePkg.sv
hw/trueDualPortRam.sv
hw/textureBuffer.sv
hw/textureConfig.sv
hw/texelFilter.sv
hw/textureUnit.sv
tests/tbClock.sv
tests/textureUnitTb.sv
